// File: all.f
verilog/lsu_pkg.sv
verilog/load_buffer.sv
verilog/scratch_sram.sv
verilog/lsu_load_top.sv
test/axi_dram_model.sv
test/tb_lsu_load.sv

// File: run.sh
#!/bin/sh
# build and run the load unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f all.f --top-module tb_lsu_load -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/Vtb_lsu_load > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "no pass line found in sim.log"
    exit 1
fi
exit 0

// File: test/axi_dram_model.sv
`default_nettype none

module axi_dram_model (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         cmd_start,
    input  wire  [2:0]  fail_attempts,
    input  wire         fail_kind,
    input  wire  [7:0]  fail_beat,
    input  wire  [7:0]  arid,
    input  wire  [11:0] araddr,
    input  wire  [7:0]  arlen,
    input  wire         arvalid,
    output logic        arready,
    output logic [7:0]  rid,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    output logic        rvalid,
    input  wire         rready
);
    timeunit 1ns;
    timeprecision 1ps;

    logic        in_data;
    logic        wait_set;
    logic [1:0]  wait_cnt;
    logic [7:0]  id_q;
    logic [7:0]  len_q;
    logic [7:0]  beat;
    logic [11:0] addr_q;
    logic [2:0]  att_cnt;
    logic [2:0]  att_q;
    logic [7:0]  nb;
    logic        bad;

    // data word stored at a dram word address
    function automatic logic [31:0] dram_word(input logic [11:0] a);
        return ({20'd0, a} * 32'h9e3779b1) ^ 32'h5ac30f96;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            rlast <= 1'b0;
            rid <= 8'd0;
            rdata <= 32'd0;
            rresp <= 2'b00;
            in_data <= 1'b0;
            wait_set <= 1'b0;
            wait_cnt <= 2'd0;
            att_cnt <= 3'd0;
            beat <= 8'd0;
        end else begin
            if (cmd_start) begin
                att_cnt <= 3'd0;
            end
            arready <= 1'b0;
            if (!in_data) begin
                if (arvalid && arready) begin
                    id_q <= arid;
                    addr_q <= araddr;
                    len_q <= arlen;
                    att_q <= att_cnt;
                    att_cnt <= att_cnt + 3'd1;
                    in_data <= 1'b1;
                    wait_set <= 1'b0;
                    beat <= 8'd0;
                end else if (arvalid && !wait_set) begin
                    wait_cnt <= 2'($urandom % 4);
                    wait_set <= 1'b1;
                end else if (arvalid && wait_cnt == 2'd0) begin
                    arready <= 1'b1;
                end else if (arvalid) begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end else if (rvalid && rready && rlast) begin
                rvalid <= 1'b0;
                rlast <= 1'b0;
                in_data <= 1'b0;
            end else if (!rvalid || rready) begin
                nb = (rvalid && rready) ? beat + 8'd1 : beat;
                beat <= nb;
                // roughly one cycle in four is a gap
                if ($urandom % 4 != 0) begin
                    bad = (att_q < fail_attempts) && (nb == fail_beat);
                    rvalid <= 1'b1;
                    rdata <= dram_word(addr_q + {4'd0, nb});
                    rlast <= (nb == len_q);
                    rresp <= (bad && !fail_kind) ? 2'b10 : 2'b00;
                    rid <= (bad && fail_kind) ? (id_q ^ 8'h80) : id_q;
                end else begin
                    rvalid <= 1'b0;
                    rlast <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tb_lsu_load.sv
`default_nettype none

module tb_lsu_load;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CMDS = 9;

    logic clk, rst_n;
    logic ctrl_load_arvld;
    logic [7:0] ctrl_load_arid, ctrl_load_arlen, ctrl_load_ld_addr;
    logic [11:0] ctrl_load_dram_araddr;
    logic [1:0] ctrl_load_sram_type;
    wire load_busy, load_done, load_error;
    wire [7:0] load_axi_arid, load_axi_arlen, load_axi_rid;
    wire [11:0] load_axi_araddr;
    wire [2:0] load_axi_arsize;
    wire [1:0] load_axi_arburst, load_axi_rresp;
    wire load_axi_arvalid, load_axi_arready, load_axi_rvalid, load_axi_rlast, load_axi_rready;
    wire [31:0] load_axi_rdata, rd_data;
    logic rd_en;
    logic [1:0] rd_type;
    logic [7:0] rd_addr;
    logic [2:0] fail_attempts;
    logic fail_kind;
    logic [7:0] fail_beat;

    // command table
    logic [7:0] t_id [NUM_CMDS];
    logic [11:0] t_addr [NUM_CMDS];
    logic [7:0] t_len [NUM_CMDS];
    logic [1:0] t_bank [NUM_CMDS];
    logic [7:0] t_row [NUM_CMDS];
    int t_fail [NUM_CMDS];
    logic t_kind [NUM_CMDS];
    int t_beat [NUM_CMDS];
    logic t_err [NUM_CMDS];

    logic [31:0] exp_mem [4][256];
    bit known [4][256];
    int ar_accepts, wen_count, ar_base, wen_base, exp_ar, exp_wen, total_beats;
    logic ar_wait_q;
    logic [7:0] held_id, held_len;
    logic [11:0] held_addr;

    // fields of the command in flight
    logic [7:0] cur_id, cur_len;
    logic [11:0] cur_addr;

    lsu_load_top lsu_load_top_i (.*);

    axi_dram_model axi_dram_model_i (
        .clk(clk), .rst_n(rst_n), .cmd_start(ctrl_load_arvld & ~load_busy),
        .fail_attempts(fail_attempts), .fail_kind(fail_kind), .fail_beat(fail_beat),
        .arid(load_axi_arid), .araddr(load_axi_araddr), .arlen(load_axi_arlen),
        .arvalid(load_axi_arvalid), .arready(load_axi_arready),
        .rid(load_axi_rid), .rdata(load_axi_rdata), .rresp(load_axi_rresp),
        .rlast(load_axi_rlast), .rvalid(load_axi_rvalid), .rready(load_axi_rready)
    );

    function automatic logic [31:0] dram_word(input logic [11:0] a);
        return ({20'd0, a} * 32'h9e3779b1) ^ 32'h5ac30f96;
    endfunction

    task automatic stop_with(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic add_cmd(input int i, input logic [7:0] id, input logic [11:0] addr,
                           input logic [7:0] len, input logic [1:0] bank,
                           input logic [7:0] row, input int fails, input logic kind,
                           input int beat, input logic err);
        t_id[i] = id;
        t_addr[i] = addr;
        t_len[i] = len;
        t_bank[i] = bank;
        t_row[i] = row;
        t_fail[i] = fails;
        t_kind[i] = kind;
        t_beat[i] = beat;
        t_err[i] = err;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // AR accepts, scratchpad writes and address hold while waiting
    always @(posedge clk) begin
        if (load_axi_arvalid && load_axi_arready) begin
            ar_accepts <= ar_accepts + 1;
            assert (load_axi_arsize == 3'b010 && load_axi_arburst == 2'b01)
                else stop_with($sformatf("ERROR %0t: bad arsize or arburst", $time));
            // every request, resends too, carries the original command
            assert (load_axi_arid == cur_id && load_axi_araddr == cur_addr &&
                    load_axi_arlen == cur_len)
                else stop_with($sformatf("ERROR %0t: AR fields differ from the command",
                                         $time));
        end
        if (lsu_load_top_i.sram_wen) begin
            wen_count <= wen_count + 1;
        end
        if (ar_wait_q) begin
            assert (load_axi_arvalid && load_axi_arid == held_id &&
                    load_axi_araddr == held_addr && load_axi_arlen == held_len)
                else stop_with($sformatf("ERROR %0t: AR fields moved while waiting", $time));
        end
        ar_wait_q <= load_axi_arvalid && !load_axi_arready;
        held_id <= load_axi_arid;
        held_addr <= load_axi_araddr;
        held_len <= load_axi_arlen;
    end

    initial begin
        #1;
        total_beats = 0;
        for (int i = 0; i < NUM_CMDS; i++) begin
            total_beats += int'(t_len[i]) + 1;
        end
        #(total_beats * 64 * 20);
        stop_with("timeout: a load did not finish in the allowed time");
    end

    initial begin
        void'($urandom(32'h1fde));
        rst_n = 1'b0;
        ctrl_load_arvld = 1'b0;
        ctrl_load_arid = 8'd0;
        ctrl_load_dram_araddr = 12'd0;
        ctrl_load_arlen = 8'd0;
        ctrl_load_ld_addr = 8'd0;
        ctrl_load_sram_type = 2'd0;
        rd_en = 1'b0;
        rd_type = 2'd0;
        rd_addr = 8'd0;
        fail_attempts = 3'd0;
        fail_kind = 1'b0;
        fail_beat = 8'd0;
        ar_accepts = 0;
        wen_count = 0;
        ar_wait_q = 1'b0;
        cur_id = 8'd0;
        cur_addr = 12'd0;
        cur_len = 8'd0;
        for (int b = 0; b < 4; b++) begin
            for (int r = 0; r < 256; r++) begin
                known[b][r] = 1'b0;
            end
        end
        // clean loads, retried loads, a load that gives up, single beat
        // the first four share rows so a write to the wrong bank shows up
        add_cmd(0, 8'h01, 12'h000, 8'd7, 2'd0, 8'h00, 0, 1'b0, 0, 1'b0);
        add_cmd(1, 8'h02, 12'h100, 8'd15, 2'd1, 8'h00, 0, 1'b0, 0, 1'b0);
        add_cmd(2, 8'h03, 12'h200, 8'd3, 2'd2, 8'h02, 0, 1'b0, 0, 1'b0);
        add_cmd(3, 8'h04, 12'h300, 8'd5, 2'd3, 8'h04, 0, 1'b0, 0, 1'b0);
        add_cmd(4, 8'h05, 12'h400, 8'd7, 2'd0, 8'h40, 1, 1'b0, 3, 1'b0);
        add_cmd(5, 8'h06, 12'h480, 8'd9, 2'd1, 8'h50, 2, 1'b0, 0, 1'b0);
        add_cmd(6, 8'h07, 12'h500, 8'd7, 2'd2, 8'h60, 1, 1'b1, 5, 1'b0);
        add_cmd(7, 8'h08, 12'h600, 8'd7, 2'd0, 8'h00, 4, 1'b0, 4, 1'b1);
        add_cmd(8, 8'h09, 12'h700, 8'd0, 2'd3, 8'h80, 0, 1'b0, 0, 1'b0);

        repeat (4) @(posedge clk);
        assert (!load_busy && !load_done && !load_error && !load_axi_arvalid &&
                !load_axi_rready)
            else stop_with($sformatf("ERROR %0t: outputs not idle in reset", $time));
        rst_n <= 1'b1;
        @(posedge clk);

        for (int c = 0; c < NUM_CMDS; c++) begin
            ar_base = ar_accepts;
            wen_base = wen_count;
            cur_id = t_id[c];
            cur_addr = t_addr[c];
            cur_len = t_len[c];
            @(posedge clk);
            ctrl_load_arvld <= 1'b1;
            ctrl_load_arid <= t_id[c];
            ctrl_load_dram_araddr <= t_addr[c];
            ctrl_load_arlen <= t_len[c];
            ctrl_load_ld_addr <= t_row[c];
            ctrl_load_sram_type <= t_bank[c];
            fail_attempts <= 3'(t_fail[c]);
            fail_kind <= t_kind[c];
            fail_beat <= 8'(t_beat[c]);
            @(posedge clk);
            ctrl_load_arvld <= 1'b0;
            if (t_len[c] == 8'd0) begin
                // second strobe while busy must be ignored
                @(posedge clk);
                assert (load_busy)
                    else stop_with($sformatf("ERROR %0t: busy low after strobe", $time));
                ctrl_load_arvld <= 1'b1;
                ctrl_load_dram_araddr <= 12'h7f0;
                ctrl_load_ld_addr <= 8'h90;
                @(posedge clk);
                ctrl_load_arvld <= 1'b0;
            end
            while (!load_done) @(posedge clk);
            assert (load_error == t_err[c])
                else stop_with($sformatf("ERROR %0t: cmd %0d load_error %0b", $time, c,
                                         load_error));
            assert (!load_busy)
                else stop_with($sformatf("ERROR %0t: cmd %0d busy high with done", $time, c));
            repeat (2) @(posedge clk);
            exp_ar = t_err[c] ? 4 : t_fail[c] + 1;
            exp_wen = t_beat[c] * (t_err[c] ? 4 : t_fail[c]) +
                      (t_err[c] ? 0 : int'(t_len[c]) + 1);
            assert (ar_accepts - ar_base == exp_ar)
                else stop_with($sformatf("ERROR %0t: cmd %0d AR accepts %0d, expected %0d",
                                         $time, c, ar_accepts - ar_base, exp_ar));
            assert (wen_count - wen_base == exp_wen)
                else stop_with($sformatf("ERROR %0t: cmd %0d writes %0d, expected %0d",
                                         $time, c, wen_count - wen_base, exp_wen));
            for (int i = 0; i <= int'(t_len[c]); i++) begin
                if (!t_err[c] || i < t_beat[c]) begin
                    exp_mem[t_bank[c]][8'(t_row[c] + i)] = dram_word(12'(t_addr[c] + i));
                    known[t_bank[c]][8'(t_row[c] + i)] = 1'b1;
                end
            end
            // read back the row range in every bank
            for (int b = 0; b < 4; b++) begin
                for (int i = 0; i <= int'(t_len[c]); i++) begin
                    if (known[b][8'(t_row[c] + i)]) begin
                        @(posedge clk);
                        rd_en <= 1'b1;
                        rd_type <= 2'(b);
                        rd_addr <= 8'(t_row[c] + i);
                        @(posedge clk);
                        rd_en <= 1'b0;
                        @(posedge clk);
                        assert (rd_data == exp_mem[b][rd_addr])
                            else stop_with($sformatf("ERROR %0t: bank %0d row %0d read %h",
                                                     $time, b, rd_addr, rd_data));
                    end
                end
            end
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/load_buffer.sv
`default_nettype none

module load_buffer (
    input  wire                              clk,
    input  wire                              rst_n,

    // command from the controller
    input  wire                              ctrl_load_arvld,
    input  wire  [lsu_pkg::ID_W-1:0]         ctrl_load_arid,
    input  wire  [lsu_pkg::DRAM_ADDR_W-1:0]  ctrl_load_dram_araddr,
    input  wire  [lsu_pkg::LEN_W-1:0]        ctrl_load_arlen,
    input  wire  [lsu_pkg::ROW_W-1:0]        ctrl_load_ld_addr,
    input  wire  [lsu_pkg::TYPE_W-1:0]       ctrl_load_sram_type,

    // axi read address channel
    output logic [lsu_pkg::ID_W-1:0]         load_axi_arid,
    output logic [lsu_pkg::DRAM_ADDR_W-1:0]  load_axi_araddr,
    output logic [lsu_pkg::LEN_W-1:0]        load_axi_arlen,
    output logic [lsu_pkg::AXI_SIZE_W-1:0]   load_axi_arsize,
    output logic [lsu_pkg::AXI_BURST_W-1:0]  load_axi_arburst,
    output logic                             load_axi_arvalid,
    input  wire                              load_axi_arready,

    // axi read data channel
    input  wire  [lsu_pkg::ID_W-1:0]         load_axi_rid,
    input  wire  [lsu_pkg::DATA_W-1:0]       load_axi_rdata,
    input  wire  [lsu_pkg::RESP_W-1:0]       load_axi_rresp,
    input  wire                              load_axi_rlast,
    input  wire                              load_axi_rvalid,
    output logic                             load_axi_rready,

    // scratchpad write
    output logic                             sram_wen,
    output logic [lsu_pkg::TYPE_W-1:0]       sram_type,
    output logic [lsu_pkg::ROW_W-1:0]        sram_addr,
    output logic [lsu_pkg::DATA_W-1:0]       sram_din,

    // status back to the controller
    output logic                             load_busy,
    output logic                             load_done,
    output logic                             load_error
);
    import lsu_pkg::*;

    logic [LB_STATE_W-1:0] state;

    // captured command
    logic [ID_W-1:0]        cmd_id;
    logic [DRAM_ADDR_W-1:0] cmd_addr;
    logic [LEN_W-1:0]       cmd_len;
    logic [ROW_W-1:0]       cmd_row;
    logic [TYPE_W-1:0]      cmd_type;

    // per attempt tracking
    logic [LEN_W-1:0]       beat_cnt;
    logic [ROW_W-1:0]       row_ptr;
    logic [RETRY_W-1:0]     retry_cnt;
    logic                   burst_bad;
    logic                   err_flag;

    logic cmd_accept;
    logic ar_fire;
    logic r_fire;
    logic beat_last_exp;
    logic beat_bad;
    logic beat_good;
    logic attempt_bad;
    logic retry_left;

    assign cmd_accept = ctrl_load_arvld & ~load_busy;
    assign ar_fire = load_axi_arvalid & load_axi_arready;
    assign r_fire = load_axi_rvalid & load_axi_rready;

    // a beat is bad on error response, foreign id, or rlast out of place
    assign beat_last_exp = (beat_cnt == cmd_len);
    assign beat_bad = (load_axi_rresp != AXI_RESP_OKAY)
                    | (load_axi_rid != cmd_id)
                    | (load_axi_rlast != beat_last_exp);

    // nothing gets written once the attempt has gone bad
    assign beat_good = r_fire & ~beat_bad & ~burst_bad;
    assign attempt_bad = burst_bad | beat_bad;
    assign retry_left = (retry_cnt != RETRY_W'(MAX_RETRY));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= LB_IDLE;
            err_flag <= 1'b0;
        end else begin
            case (state)
                LB_IDLE, LB_FINISH: begin
                    if (cmd_accept) begin
                        state <= LB_ADDR;
                        err_flag <= 1'b0;
                    end else begin
                        state <= LB_IDLE;
                    end
                end
                LB_ADDR: begin
                    if (ar_fire) begin
                        state <= LB_DATA;
                    end
                end
                LB_DATA: begin
                    if (r_fire && load_axi_rlast) begin
                        if (!attempt_bad) begin
                            state <= LB_FINISH;
                        end else if (retry_left) begin
                            // whole burst goes out again
                            state <= LB_ADDR;
                        end else begin
                            state <= LB_FINISH;
                            err_flag <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= LB_IDLE;
                end
            endcase
        end
    end

    // command fields, held for every resend
    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            cmd_id <= ctrl_load_arid;
            cmd_addr <= ctrl_load_dram_araddr;
            cmd_len <= ctrl_load_arlen;
            cmd_row <= ctrl_load_ld_addr;
            cmd_type <= ctrl_load_sram_type;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retry_cnt <= '0;
            burst_bad <= 1'b0;
            beat_cnt <= '0;
            row_ptr <= '0;
        end else if (cmd_accept) begin
            retry_cnt <= '0;
            burst_bad <= 1'b0;
            beat_cnt <= '0;
            row_ptr <= ctrl_load_ld_addr;
        end else if (r_fire) begin
            if (load_axi_rlast) begin
                // rewind for a possible resend from the start row
                beat_cnt <= '0;
                burst_bad <= 1'b0;
                row_ptr <= cmd_row;
                if (attempt_bad && retry_left) begin
                    retry_cnt <= retry_cnt + 1'b1;
                end
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
                row_ptr <= row_ptr + 1'b1;
                if (beat_bad) begin
                    burst_bad <= 1'b1;
                end
            end
        end
    end

    // scratchpad write lands one cycle after the beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sram_wen <= 1'b0;
        end else begin
            sram_wen <= beat_good;
        end
    end

    always_ff @(posedge clk) begin
        if (r_fire) begin
            sram_addr <= row_ptr;
            sram_din <= load_axi_rdata;
        end
    end

    assign sram_type = cmd_type;

    // address channel straight from the command registers
    assign load_axi_arvalid = (state == LB_ADDR);
    assign load_axi_arid = cmd_id;
    assign load_axi_araddr = cmd_addr;
    assign load_axi_arlen = cmd_len;
    assign load_axi_arsize = AXI_SIZE_WORD;
    assign load_axi_arburst = AXI_BURST_INCR;

    // rready held for the whole data phase
    assign load_axi_rready = (state == LB_DATA);

    assign load_busy = (state == LB_ADDR) | (state == LB_DATA);
    assign load_done = (state == LB_FINISH);
    assign load_error = load_done & err_flag;

endmodule

`default_nettype wire

// File: verilog/lsu_load_top.sv
`default_nettype none

module lsu_load_top (
    input  wire                              clk,
    input  wire                              rst_n,

    // command port
    input  wire                              ctrl_load_arvld,
    input  wire  [lsu_pkg::ID_W-1:0]         ctrl_load_arid,
    input  wire  [lsu_pkg::DRAM_ADDR_W-1:0]  ctrl_load_dram_araddr,
    input  wire  [lsu_pkg::LEN_W-1:0]        ctrl_load_arlen,
    input  wire  [lsu_pkg::ROW_W-1:0]        ctrl_load_ld_addr,
    input  wire  [lsu_pkg::TYPE_W-1:0]       ctrl_load_sram_type,
    output wire                              load_busy,
    output wire                              load_done,
    output wire                              load_error,

    // axi read address channel
    output wire  [lsu_pkg::ID_W-1:0]         load_axi_arid,
    output wire  [lsu_pkg::DRAM_ADDR_W-1:0]  load_axi_araddr,
    output wire  [lsu_pkg::LEN_W-1:0]        load_axi_arlen,
    output wire  [lsu_pkg::AXI_SIZE_W-1:0]   load_axi_arsize,
    output wire  [lsu_pkg::AXI_BURST_W-1:0]  load_axi_arburst,
    output wire                              load_axi_arvalid,
    input  wire                              load_axi_arready,

    // axi read data channel
    input  wire  [lsu_pkg::ID_W-1:0]         load_axi_rid,
    input  wire  [lsu_pkg::DATA_W-1:0]       load_axi_rdata,
    input  wire  [lsu_pkg::RESP_W-1:0]       load_axi_rresp,
    input  wire                              load_axi_rlast,
    input  wire                              load_axi_rvalid,
    output wire                              load_axi_rready,

    // inspection port
    input  wire                              rd_en,
    input  wire  [lsu_pkg::TYPE_W-1:0]       rd_type,
    input  wire  [lsu_pkg::ROW_W-1:0]        rd_addr,
    output wire  [lsu_pkg::DATA_W-1:0]       rd_data
);
    import lsu_pkg::*;

    // load buffer to scratchpad
    wire              sram_wen;
    wire [TYPE_W-1:0] sram_type;
    wire [ROW_W-1:0]  sram_addr;
    wire [DATA_W-1:0] sram_din;

    load_buffer load_buffer_i (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .ctrl_load_arvld       (ctrl_load_arvld),
        .ctrl_load_arid        (ctrl_load_arid),
        .ctrl_load_dram_araddr (ctrl_load_dram_araddr),
        .ctrl_load_arlen       (ctrl_load_arlen),
        .ctrl_load_ld_addr     (ctrl_load_ld_addr),
        .ctrl_load_sram_type   (ctrl_load_sram_type),
        .load_axi_arid         (load_axi_arid),
        .load_axi_araddr       (load_axi_araddr),
        .load_axi_arlen        (load_axi_arlen),
        .load_axi_arsize       (load_axi_arsize),
        .load_axi_arburst      (load_axi_arburst),
        .load_axi_arvalid      (load_axi_arvalid),
        .load_axi_arready      (load_axi_arready),
        .load_axi_rid          (load_axi_rid),
        .load_axi_rdata        (load_axi_rdata),
        .load_axi_rresp        (load_axi_rresp),
        .load_axi_rlast        (load_axi_rlast),
        .load_axi_rvalid       (load_axi_rvalid),
        .load_axi_rready       (load_axi_rready),
        .sram_wen              (sram_wen),
        .sram_type             (sram_type),
        .sram_addr             (sram_addr),
        .sram_din              (sram_din),
        .load_busy             (load_busy),
        .load_done             (load_done),
        .load_error            (load_error)
    );

    scratch_sram scratch_sram_i (
        .clk       (clk),
        .sram_wen  (sram_wen),
        .sram_type (sram_type),
        .sram_addr (sram_addr),
        .sram_din  (sram_din),
        .rd_en     (rd_en),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

endmodule

`default_nettype wire

// File: verilog/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // dram side
    localparam int DRAM_ADDR_W = 12;
    localparam int DATA_W = 32;
    localparam int ID_W = 8;
    // burst length, n means n+1 beats
    localparam int LEN_W = 8;

    // scratchpad geometry
    localparam int ROW_W = 8;
    localparam int TYPE_W = 2;
    localparam int NUM_BANKS = 4;
    localparam int SRAM_DEPTH = 2 ** ROW_W;

    // resend policy
    localparam int MAX_RETRY = 3;
    localparam int RETRY_W = 2;

    // axi field widths
    localparam int AXI_SIZE_W = 3;
    localparam int AXI_BURST_W = 2;
    localparam int RESP_W = 2;

    // axi codes
    localparam logic [AXI_SIZE_W-1:0] AXI_SIZE_WORD = 3'b010;
    localparam logic [AXI_BURST_W-1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [RESP_W-1:0] AXI_RESP_OKAY = 2'b00;

    // load buffer fsm encoding
    localparam int LB_STATE_W = 2;
    localparam logic [LB_STATE_W-1:0] LB_IDLE = 2'd0;
    localparam logic [LB_STATE_W-1:0] LB_ADDR = 2'd1;
    localparam logic [LB_STATE_W-1:0] LB_DATA = 2'd2;
    localparam logic [LB_STATE_W-1:0] LB_FINISH = 2'd3;

endpackage

`default_nettype wire

// File: verilog/scratch_sram.sv
`default_nettype none

module scratch_sram (
    input  wire                         clk,

    // write port from the load buffer
    input  wire                         sram_wen,
    input  wire  [lsu_pkg::TYPE_W-1:0]  sram_type,
    input  wire  [lsu_pkg::ROW_W-1:0]   sram_addr,
    input  wire  [lsu_pkg::DATA_W-1:0]  sram_din,

    // host inspection port
    input  wire                         rd_en,
    input  wire  [lsu_pkg::TYPE_W-1:0]  rd_type,
    input  wire  [lsu_pkg::ROW_W-1:0]   rd_addr,
    output logic [lsu_pkg::DATA_W-1:0]  rd_data
);
    import lsu_pkg::*;

    logic [NUM_BANKS-1:0] bank_we;
    logic [DATA_W-1:0]    bank_rdata [NUM_BANKS];

    genvar b;
    generate
        for (b = 0; b < NUM_BANKS; b++) begin : g_bank
            // one array per bank
            logic [DATA_W-1:0] mem [SRAM_DEPTH];

            // bank select from the write type
            assign bank_we[b] = sram_wen & (sram_type == TYPE_W'(b));

            always_ff @(posedge clk) begin
                if (bank_we[b]) begin
                    mem[sram_addr] <= sram_din;
                end
            end

            // every bank looks up the same row, type picks one below
            assign bank_rdata[b] = mem[rd_addr];
        end
    endgenerate

    // registered read, holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= bank_rdata[rd_type];
        end
    end

endmodule

`default_nettype wire
